//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_ti_cart_mem
FILELIST  ?= sources.f
LOG       ?= sim.log
PASS_MSG  := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- cart_erase.sv
// Walk restarts only from idle; a start edge during a running erase is ignored
`timescale 1ns/1ps

module cart_erase (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 erase_start_i,
	input  logic                 er_ready_i,
	output ti_mem_pkg::mem_req_t er_req_o,
	output logic                 erase_busy_o
);

	logic                         start_q;  // Start edge detect
	logic                         start_go;
	logic                         busy_q;
	logic                         valid_q;
	logic                         last_q;   // Final address written
	logic                         accept;
	logic [ti_mem_pkg::DL_AW-1:0] addr_q;
	logic [ti_mem_pkg::DL_AW-1:0] addr_nxt;

	assign start_go = erase_start_i && !start_q && !busy_q;
	assign accept   = valid_q && er_ready_i;

	// Next walk address with the two region jumps
	always_comb begin
		if (addr_q == ti_mem_pkg::ERASE_END_A) begin
			addr_nxt = ti_mem_pkg::ERASE_JUMP_A;  // Into cart GROM
		end else if (addr_q == ti_mem_pkg::ERASE_END_B) begin
			addr_nxt = ti_mem_pkg::ERASE_JUMP_B;  // Into scratch
		end else begin
			addr_nxt = addr_q + 27'd1;
		end
	end

	// ============================================================
	// Walk control
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			start_q <= 1'b0;
			busy_q  <= 1'b0;
			valid_q <= 1'b0;
			last_q  <= 1'b0;
		end else begin
			start_q <= erase_start_i;
			if (start_go) begin
				busy_q  <= 1'b1;
				valid_q <= 1'b1;
				last_q  <= 1'b0;
			end else if (accept) begin
				valid_q <= 1'b0;                      // One idle cycle between writes
				last_q  <= (addr_q == ti_mem_pkg::ERASE_LAST);
			end else if (busy_q && !valid_q) begin
				if (last_q) begin
					busy_q <= 1'b0;                   // Done
				end else begin
					valid_q <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (start_go) begin
			addr_q <= '0;
		end else if (accept) begin
			addr_q <= addr_nxt;
		end
	end

	always_comb begin
		er_req_o       = '0;                        // Zero data, whole word
		er_req_o.addr  = addr_q[ti_mem_pkg::MEM_AW-1:0];
		er_req_o.we    = 1'b1;
		er_req_o.valid = valid_q;
	end

	assign erase_busy_o = busy_q;

	// Only cart ROM, cart GROM and scratch ever get cleared
	a_erase_region: assert property (@(posedge clk_sys) disable iff (RESET)
		valid_q |-> ((addr_q <= ti_mem_pkg::ERASE_END_A) ||
		((addr_q >= ti_mem_pkg::ERASE_JUMP_A) && (addr_q <= ti_mem_pkg::ERASE_END_B)) ||
		((addr_q >= ti_mem_pkg::ERASE_JUMP_B) && (addr_q <= ti_mem_pkg::ERASE_LAST))));

endmodule

//--- console_hold.sv
// Hold length is fixed at HOLD_CYCLES plus one clock after the last busy cycle
`timescale 1ns/1ps

module console_hold (
	input  logic clk_sys,
	input  logic RESET,
	input  logic dl_active_i,
	input  logic erase_busy_i,
	output logic console_hold_o
);

	logic       init_q;   // No download seen yet
	logic [7:0] cnt_q;    // Post-activity countdown

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			init_q <= 1'b1;
		end else if (dl_active_i) begin
			init_q <= 1'b0;                       // First download releases it
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cnt_q <= 8'd0;
		end else if (dl_active_i || erase_busy_i) begin
			cnt_q <= ti_mem_pkg::HOLD_CYCLES;    // Reload while active
		end else if (cnt_q != 8'd0) begin
			cnt_q <= cnt_q - 8'd1;
		end
	end

	assign console_hold_o = init_q || (cnt_q != 8'd0);

endmodule

//--- mem_arbiter.sv
// Purely combinational; requesters must hold their request until they see ready
`timescale 1ns/1ps

module mem_arbiter (
	input  ti_mem_pkg::mem_req_t ld_req_i,
	input  ti_mem_pkg::mem_req_t er_req_i,
	input  ti_mem_pkg::mem_req_t cpu_req_i,
	input  logic                 mem_ready_i,
	output ti_mem_pkg::mem_req_t mem_req_o,
	output logic                 ld_ready_o,
	output logic                 er_ready_o,
	output logic                 cpu_ready_o
);

	logic gnt_ld;
	logic gnt_er;
	logic gnt_cpu;

	// ============================================================
	// Fixed priority grant
	// ============================================================
	always_comb begin
		gnt_ld  = ld_req_i.valid;                          // Download first
		gnt_er  = er_req_i.valid && !ld_req_i.valid;       // Then erase
		gnt_cpu = cpu_req_i.valid && !ld_req_i.valid && !er_req_i.valid;
	end

	// Port mux, CPU path when idle
	always_comb begin
		if (gnt_ld) begin
			mem_req_o = ld_req_i;
		end else if (gnt_er) begin
			mem_req_o = er_req_i;
		end else begin
			mem_req_o = cpu_req_i;                         // Passed through unchanged
		end
	end

	// Ready goes back to the winner only
	assign ld_ready_o  = mem_ready_i && gnt_ld;
	assign er_ready_o  = mem_ready_i && gnt_er;
	assign cpu_ready_o = mem_ready_i && gnt_cpu;

endmodule

//--- rom_load_map.sv
// Holds a single pending write; the download source must not strobe again before acceptance
`timescale 1ns/1ps

module rom_load_map (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 dl_we_i,
	input  ti_mem_pkg::dl_wr_t   dl_wr_i,
	input  logic                 ld_ready_i,
	output ti_mem_pkg::mem_req_t ld_req_o,
	output logic [7:0]           dsr_hash_o
);

	logic [ti_mem_pkg::DL_AW-1:0] base;     // Region offset
	logic [ti_mem_pkg::DL_AW-1:0] limit;    // File bytes kept
	logic                         kept;     // Index goes to SDRAM
	logic                         limited;  // Limit applies
	logic [ti_mem_pkg::DL_AW-1:0] map_addr;
	logic                         map_wr;
	ti_mem_pkg::mem_req_t         req_q;
	logic [7:0]                   hash_q;

	// ============================================================
	// Index decode
	// ============================================================
	always_comb begin
		base    = '0;
		limit   = '0;
		kept    = 1'b1;
		limited = 1'b1;
		case (dl_wr_i.index)
			ti_mem_pkg::IDX_CART_ROM: begin
				limited = 1'b0;                 // Whole file
				if (dl_wr_i.addr >= ti_mem_pkg::CART_HI_START) begin
					base = ti_mem_pkg::CART_HI_OFS;
				end
			end
			ti_mem_pkg::IDX_CART_GROM: begin
				base  = ti_mem_pkg::CART_GROM_BASE;
				limit = ti_mem_pkg::CART_GROM_LIMIT;
			end
			ti_mem_pkg::IDX_SYS_GROM: begin
				base  = ti_mem_pkg::SYS_GROM_BASE;
				limit = ti_mem_pkg::SYS_GROM_LIMIT;
			end
			ti_mem_pkg::IDX_SYS_ROM: begin
				base  = ti_mem_pkg::SYS_ROM_BASE;
				limit = ti_mem_pkg::SYS_ROM_LIMIT;
			end
			ti_mem_pkg::IDX_DISK_DSR: begin
				base  = ti_mem_pkg::DISK_DSR_BASE;
				limit = ti_mem_pkg::DISK_DSR_LIMIT;
			end
			ti_mem_pkg::IDX_TIPI_DSR: begin
				base  = ti_mem_pkg::TIPI_DSR_BASE;
				limit = ti_mem_pkg::TIPI_DSR_LIMIT;
			end
			ti_mem_pkg::IDX_PCODE: begin
				base  = ti_mem_pkg::PCODE_BASE;
				limit = ti_mem_pkg::PCODE_LIMIT;
			end
			ti_mem_pkg::IDX_SPEECH: kept = 1'b0; // Separate speech ROM
			default:                kept = 1'b0; // Boot ROM, M99, unknown
		endcase
		map_addr = dl_wr_i.addr + base;
		map_wr   = dl_we_i && kept && (!limited || (dl_wr_i.addr < limit));
	end

	// ============================================================
	// Pending request
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			req_q.valid <= 1'b0;
		end else if (map_wr) begin
			// Even and odd bytes swap inside the SDRAM word
			req_q.addr  <= {map_addr[ti_mem_pkg::MEM_AW-1:1], ~map_addr[0]};
			req_q.wdata <= {2{dl_wr_i.data}};   // Same byte on both halves
			req_q.be    <= 2'b00;
			req_q.we    <= 1'b1;
			req_q.rd    <= 1'b0;
			req_q.valid <= 1'b1;
		end else if (ld_ready_i) begin
			req_q.valid <= 1'b0;                // Accepted
		end
	end

	assign ld_req_o = req_q;

	// Disk DSR signature, count of odd bytes
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			hash_q <= 8'd0;
		end else if (dl_we_i && (dl_wr_i.index == ti_mem_pkg::IDX_DISK_DSR)) begin
			if (dl_wr_i.addr == '0) begin
				hash_q <= {7'd0, dl_wr_i.data[0]};  // New file restarts the sum
			end else begin
				hash_q <= hash_q + {7'd0, dl_wr_i.data[0]};
			end
		end
	end

	assign dsr_hash_o = hash_q;

	// Source cannot stall, so the arbiter must drain us before the next byte
	a_no_overrun: assert property (@(posedge clk_sys) disable iff (RESET)
		dl_we_i |-> (!req_q.valid || ld_ready_i));

endmodule

//--- sources.f
ti_mem_pkg.sv
rom_load_map.sv
cart_erase.sv
mem_arbiter.sv
console_hold.sv
ti_cart_mem_top.sv
tb_ti_cart_mem.sv

//--- tb_ti_cart_mem.sv
// Full erase walk takes about 1.5M cycles; memory ready is random but repeats from a fixed seed
`timescale 1ns/1ps

module tb_ti_cart_mem;

	localparam int WAIT_MAX  = 200;                // Per handshake wait
	localparam int HOLD_MAX  = 400;
	localparam int ERASE_MAX = 4000000;            // Whole erase walk

	logic                 clk_sys = 1'b0;
	logic                 RESET;
	logic                 dl_active_i;
	logic                 dl_we_i;
	ti_mem_pkg::dl_wr_t   dl_wr_i;
	logic                 erase_start_i;
	logic                 erase_busy_o;
	ti_mem_pkg::mem_req_t cpu_req_i;
	logic                 cpu_ready_o;
	logic [15:0]          cpu_rdata_o;
	logic                 mem_ready_i = 1'b0;
	logic [15:0]          mem_rdata_i = 16'h0000;
	ti_mem_pkg::mem_req_t mem_req_o;
	logic [7:0]           dsr_hash_o;
	logic                 console_hold_o;

	integer seed = 32'h43ee;
	int     errors;
	int     checks;

	// Stimulus table, one entry per mapping case
	string       row_name[$];
	logic [7:0]  row_idx[$];
	logic [26:0] row_addr[$];
	logic [7:0]  row_data[$];
	logic        row_wr[$];                        // Memory write expected
	logic [25:0] row_exp[$];                       // Word address after byte swap

	ti_cart_mem_top i_dut (.*);

	always #4 clk_sys = ~clk_sys;

	// Memory responder, ready about 3 cycles in 4
	always @(posedge clk_sys) begin
		mem_ready_i <= (($random(seed) & 3) != 0);
		mem_rdata_i <= 16'($random(seed));
	end

	task automatic check_eq(input string name, input logic [63:0] exp_v, input logic [63:0] act_v);
		checks++;
		assert (act_v === exp_v) else begin
			$display("Fail %s: expected %0h, actual %0h", name, exp_v, act_v);
			errors++;
		end
	endtask

	task automatic check_true(input string what, input logic cond);
		checks++;
		assert (cond) else begin
			$display("Error: %s", what);
			errors++;
		end
	endtask

	task automatic add_row(input string name, input logic [7:0] idx, input logic [26:0] addr,
			input logic [7:0] data, input logic wr, input logic [25:0] exp_addr);
		row_name.push_back(name);
		row_idx.push_back(idx);
		row_addr.push_back(addr);
		row_data.push_back(data);
		row_wr.push_back(wr);
		row_exp.push_back(exp_addr);
	endtask

	// Called at a falling edge; returns with the accepting edge still ahead
	task automatic wait_accept(input string name, output logic ok);
		int n;
		n = 0;
		while (!(mem_req_o.valid && mem_ready_i) && n < WAIT_MAX) begin
			@(negedge clk_sys);
			n++;
		end
		ok = mem_req_o.valid && mem_ready_i;
		check_true({name, ": no memory acceptance before timeout"}, ok);
	endtask

	task automatic send_byte(input string name, input logic [7:0] idx, input logic [26:0] addr,
			input logic [7:0] data, input logic wr, input logic [25:0] exp_addr);
		logic ok;
		@(posedge clk_sys);
		dl_we_i <= 1'b1;
		dl_wr_i <= {idx, addr, data};
		@(posedge clk_sys);
		dl_we_i <= 1'b0;                           // One strobe only
		@(negedge clk_sys);
		check_eq({name, " valid"}, 64'(wr), 64'(mem_req_o.valid));
		if (wr) begin
			wait_accept(name, ok);
			if (ok) begin
				check_eq({name, " addr"}, 64'(exp_addr), 64'(mem_req_o.addr));
				check_eq({name, " payload"}, 64'({data, data, 4'b0010}),
					64'({mem_req_o.wdata, mem_req_o.be, mem_req_o.we, mem_req_o.rd}));
			end
			@(posedge clk_sys);                    // Accepting edge
		end else begin
			repeat (4) begin
				@(negedge clk_sys);
				check_eq({name, " suppressed"}, 64'd0, 64'(mem_req_o.valid));
			end
		end
	endtask

	// Erase order 0..7FFFF, 86000..9FFFF, FD000..FDFFE
	function automatic logic [26:0] next_walk(input logic [26:0] a);
		if (a == 27'h007FFFF) begin
			return 27'h0086000;
		end else if (a == 27'h009FFFF) begin
			return 27'h00FD000;
		end
		return a + 27'd1;
	endfunction

	initial begin
		int                   i;
		int                   n;
		int                   odd_cnt;
		int                   erase_cnt;
		logic                 ok;
		logic [7:0]           d;
		logic [26:0]          walk;
		ti_mem_pkg::mem_req_t cpu_req;

		RESET         = 1'b1;
		dl_active_i   = 1'b0;
		dl_we_i       = 1'b0;
		dl_wr_i       = '0;
		erase_start_i = 1'b0;
		cpu_req_i     = '0;
		errors        = 0;
		checks        = 0;
		repeat (3) @(posedge clk_sys);
		RESET <= 1'b0;
		@(negedge clk_sys);
		check_eq("reset valid", 64'd0, 64'(mem_req_o.valid));
		check_eq("reset busy", 64'd0, 64'(erase_busy_o));
		check_eq("reset cpu ready", 64'd0, 64'(cpu_ready_o));
		repeat (20) begin
			@(negedge clk_sys);
			check_eq("initial hold", 64'd1, 64'(console_hold_o)); // No download yet
		end

		// ============================================================
		// Mapping table
		// ============================================================
		add_row("cart rom low", 8'd2, 27'h0000123, 8'h5A, 1'b1, 26'h0000122);
		add_row("cart rom top", 8'd2, 27'h007FFFF, 8'hA5, 1'b1, 26'h007FFFE);
		add_row("cart rom hi", 8'd2, 27'h0080000, 8'h3C, 1'b1, 26'h0200001);
		add_row("cart grom below", 8'd3, 27'h0029FFF, 8'h11, 1'b1, 26'h00AFFFE);
		add_row("cart grom limit", 8'd3, 27'h002A000, 8'h22, 1'b0, 26'h0);
		add_row("sys grom base", 8'd4, 27'h0000000, 8'h33, 1'b1, 26'h0080001);
		add_row("sys grom limit", 8'd4, 27'h0006000, 8'h44, 1'b0, 26'h0);
		add_row("sys rom below", 8'd5, 27'h0001FFF, 8'h55, 1'b1, 26'h00FFFFE);
		add_row("sys rom limit", 8'd5, 27'h0002000, 8'h66, 1'b0, 26'h0);
		add_row("speech", 8'd6, 27'h0000010, 8'h77, 1'b0, 26'h0);
		add_row("disk dsr below", 8'd7, 27'h0007FFF, 8'h88, 1'b1, 26'h00B7FFE);
		add_row("disk dsr limit", 8'd7, 27'h0008000, 8'h99, 1'b0, 26'h0);
		add_row("tipi dsr below", 8'd8, 27'h0000FFF, 8'hAA, 1'b1, 26'h00B8FFE);
		add_row("tipi dsr limit", 8'd8, 27'h0001000, 8'hBB, 1'b0, 26'h0);
		add_row("pcode below", 8'd9, 27'h0012FFF, 8'hCC, 1'b1, 26'h00CBFFE);
		add_row("pcode limit", 8'd9, 27'h0013000, 8'hDD, 1'b0, 26'h0);
		add_row("boot rom 0", 8'd0, 27'h0000004, 8'hEE, 1'b0, 26'h0);
		add_row("boot rom 1", 8'd1, 27'h0000004, 8'hEF, 1'b0, 26'h0);
		add_row("unknown index", 8'h20, 27'h0000004, 8'hF0, 1'b0, 26'h0);
		@(posedge clk_sys);
		dl_active_i <= 1'b1;                       // Download starts, releases initial hold
		for (i = 0; i < row_name.size(); i++) begin
			send_byte(row_name[i], row_idx[i], row_addr[i], row_data[i], row_wr[i], row_exp[i]);
		end

		// Disk DSR hash over a fresh file
		odd_cnt = 0;
		for (i = 0; i < 10; i++) begin
			d = 8'(i * 8'h35 + 8'h11);
			odd_cnt += d[0];
			send_byte("dsr hash byte", 8'd7, 27'(i), d, 1'b1, 26'h00B0000 | 26'(i ^ 1));
		end
		@(negedge clk_sys);
		check_eq("dsr hash", 64'(odd_cnt), 64'(dsr_hash_o));

		// ============================================================
		// Priority, CPU waits behind the loader
		// ============================================================
		cpu_req       = '0;
		cpu_req.addr  = 26'h00155AA;
		cpu_req.be    = 2'b11;
		cpu_req.rd    = 1'b1;
		cpu_req.valid = 1'b1;
		@(posedge clk_sys);
		dl_we_i <= 1'b1;
		dl_wr_i <= {8'd2, 27'h0000040, 8'hC3};
		@(posedge clk_sys);
		dl_we_i   <= 1'b0;
		cpu_req_i <= cpu_req;                      // Loader request already registered
		@(negedge clk_sys);
		n = 0;
		while (!(mem_req_o.valid && mem_req_o.we && mem_ready_i) && n < WAIT_MAX) begin
			check_true("priority: CPU accepted while download pending", !cpu_ready_o);
			@(negedge clk_sys);
			n++;
		end
		ok = mem_req_o.valid && mem_req_o.we && mem_ready_i;
		check_true("priority: download request never accepted", ok);
		check_true("priority: CPU accepted while download pending", !cpu_ready_o);
		check_eq("priority dl addr", 64'h41, 64'(mem_req_o.addr));
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_eq("cpu forward", 64'(cpu_req), 64'(mem_req_o));
		n = 0;
		while (!cpu_ready_o && n < WAIT_MAX) begin
			@(negedge clk_sys);
			n++;
		end
		check_true("priority: CPU never got ready", cpu_ready_o);
		check_eq("cpu rdata", 64'(mem_rdata_i), 64'(cpu_rdata_o));
		@(posedge clk_sys);
		cpu_req_i <= '0;

		// Hold release after download ends
		dl_active_i <= 1'b0;
		n  = 0;
		ok = 1'b1;
		while (ok && n < HOLD_MAX) begin
			@(posedge clk_sys);
			n++;
			@(negedge clk_sys);
			ok = console_hold_o;
		end
		check_true("hold: console hold never released", !ok);
		checks++;
		assert (n >= 255 && n <= 257) else begin
			$display("Fail hold release: expected 255 to 257 cycles, actual %0d", n);
			errors++;
		end

		// ============================================================
		// Erase walk
		// ============================================================
		@(posedge clk_sys);
		erase_start_i <= 1'b1;
		@(posedge clk_sys);
		erase_start_i <= 1'b0;
		@(negedge clk_sys);
		n = 0;
		while (!erase_busy_o && n < WAIT_MAX) begin
			@(negedge clk_sys);
			n++;
		end
		check_true("erase: busy never rose", erase_busy_o);
		walk      = '0;
		erase_cnt = 0;
		n         = 0;
		while (erase_busy_o && n < ERASE_MAX) begin
			if (n == 1) begin
				check_eq("erase hold", 64'd1, 64'(console_hold_o)); // Reloaded by busy
			end
			if (mem_req_o.valid && mem_ready_i) begin
				check_eq("erase addr", 64'(walk[25:0]), 64'(mem_req_o.addr));
				check_eq("erase payload", 64'h2,
					64'({mem_req_o.wdata, mem_req_o.be, mem_req_o.we, mem_req_o.rd}));
				walk = next_walk(walk);
				erase_cnt++;
			end
			@(negedge clk_sys);
			n++;
		end
		check_true("erase: busy never fell", !erase_busy_o);
		check_eq("erase count", 64'h9AFFF, 64'(erase_cnt)); // 80000 + 1A000 + FFF

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- ti_cart_mem_top.sv
// Single SDRAM request port shared by loader, eraser and CPU; CPU is starved while others run
`timescale 1ns/1ps

module ti_cart_mem_top (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 dl_active_i,
	input  logic                 dl_we_i,
	input  ti_mem_pkg::dl_wr_t   dl_wr_i,
	input  logic                 erase_start_i,
	output logic                 erase_busy_o,
	input  ti_mem_pkg::mem_req_t cpu_req_i,
	output logic                 cpu_ready_o,
	output logic [15:0]          cpu_rdata_o,
	input  logic                 mem_ready_i,
	input  logic [15:0]          mem_rdata_i,
	output ti_mem_pkg::mem_req_t mem_req_o,
	output logic [7:0]           dsr_hash_o,
	output logic                 console_hold_o
);

	ti_mem_pkg::mem_req_t ld_req;
	ti_mem_pkg::mem_req_t er_req;
	logic                 ld_ready;
	logic                 er_ready;
	logic                 erase_busy;

	// ============================================================
	// Requesters
	// ============================================================
	rom_load_map i_load (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.dl_we_i    (dl_we_i),
		.dl_wr_i    (dl_wr_i),
		.ld_ready_i (ld_ready),
		.ld_req_o   (ld_req),
		.dsr_hash_o (dsr_hash_o)
	);

	cart_erase i_erase (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.erase_start_i (erase_start_i),
		.er_ready_i    (er_ready),
		.er_req_o      (er_req),
		.erase_busy_o  (erase_busy)
	);

	mem_arbiter i_arb (
		.ld_req_i    (ld_req),
		.er_req_i    (er_req),
		.cpu_req_i   (cpu_req_i),
		.mem_ready_i (mem_ready_i),
		.mem_req_o   (mem_req_o),
		.ld_ready_o  (ld_ready),
		.er_ready_o  (er_ready),
		.cpu_ready_o (cpu_ready_o)
	);

	console_hold i_hold (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.dl_active_i    (dl_active_i),
		.erase_busy_i   (erase_busy),
		.console_hold_o (console_hold_o)
	);

	assign erase_busy_o = erase_busy;
	assign cpu_rdata_o  = mem_rdata_i;      // Read data only matters to the CPU

endmodule

//--- ti_mem_pkg.sv
// Shared memory request types and fixed console memory map; byte addresses are 27 bits wide
package ti_mem_pkg;

	// ============================================================
	// Widths
	// ============================================================
	localparam int MEM_AW = 26;                 // SDRAM word address
	localparam int DL_AW  = 27;                 // Download byte address

	// One request on the shared memory port
	typedef struct packed {
		logic [MEM_AW-1:0] addr;
		logic [15:0]       wdata;
		logic [1:0]        be;                  // Byte enables, 0 = whole word
		logic              we;
		logic              rd;
		logic              valid;
	} mem_req_t;

	// One byte from the download stream
	typedef struct packed {
		logic [7:0]       index;                // File slot
		logic [DL_AW-1:0] addr;                 // Offset inside the file
		logic [7:0]       data;
	} dl_wr_t;

	// ============================================================
	// Download index codes
	// ============================================================
	localparam logic [7:0] IDX_CART_ROM  = 8'd2;
	localparam logic [7:0] IDX_CART_GROM = 8'd3;
	localparam logic [7:0] IDX_SYS_GROM  = 8'd4;
	localparam logic [7:0] IDX_SYS_ROM   = 8'd5;
	localparam logic [7:0] IDX_SPEECH    = 8'd6; // Speech ROM lives off SDRAM
	localparam logic [7:0] IDX_DISK_DSR  = 8'd7;
	localparam logic [7:0] IDX_TIPI_DSR  = 8'd8;
	localparam logic [7:0] IDX_PCODE     = 8'd9;

	// ============================================================
	// Storage regions
	// ============================================================
	// Cart ROM above 512K sits past the SAMS RAM
	localparam logic [DL_AW-1:0] CART_HI_START   = 27'h0080000;
	localparam logic [DL_AW-1:0] CART_HI_OFS     = 27'h0180000;
	localparam logic [DL_AW-1:0] CART_GROM_BASE  = 27'h0086000;
	localparam logic [DL_AW-1:0] CART_GROM_LIMIT = 27'h002A000; // 168K
	localparam logic [DL_AW-1:0] SYS_GROM_BASE   = 27'h0080000;
	localparam logic [DL_AW-1:0] SYS_GROM_LIMIT  = 27'h0006000; // 24K
	localparam logic [DL_AW-1:0] SYS_ROM_BASE    = 27'h00FE000;
	localparam logic [DL_AW-1:0] SYS_ROM_LIMIT   = 27'h0002000; // 8K
	localparam logic [DL_AW-1:0] DISK_DSR_BASE   = 27'h00B0000;
	localparam logic [DL_AW-1:0] DISK_DSR_LIMIT  = 27'h0008000; // 32K
	localparam logic [DL_AW-1:0] TIPI_DSR_BASE   = 27'h00B8000;
	localparam logic [DL_AW-1:0] TIPI_DSR_LIMIT  = 27'h0001000; // Only 4K of the file used
	localparam logic [DL_AW-1:0] PCODE_BASE      = 27'h00B9000;
	localparam logic [DL_AW-1:0] PCODE_LIMIT     = 27'h0013000; // 76K

	// Erase walk, three regions with two jumps
	localparam logic [DL_AW-1:0] ERASE_END_A  = 27'h007FFFF; // End of cart ROM area
	localparam logic [DL_AW-1:0] ERASE_JUMP_A = 27'h0086000; // Cart GROM area
	localparam logic [DL_AW-1:0] ERASE_END_B  = 27'h009FFFF;
	localparam logic [DL_AW-1:0] ERASE_JUMP_B = 27'h00FD000; // Scratch area
	localparam logic [DL_AW-1:0] ERASE_LAST   = 27'h00FDFFE;

	// Console hold after download or erase
	localparam logic [7:0] HOLD_CYCLES = 8'd255;

endpackage
